// File: src.f
source/common_pkg.sv
source/mini_mem.sv
source/mini_rf.sv
source/mini_alu.sv
source/mini_core.sv
source/mini_mem_wrap.sv
source/mini_core_top.sv
bench/mini_core_asserts.sv
bench/mini_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mini_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(EXE)
	-./$(EXE) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/mini_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mini_core_tb
import common_pkg::*;
();

localparam int          CLK_PERIOD  = 4;                   // ns
localparam int          RST_CYCLES  = 10;
localparam logic [31:0] SEED        = 32'hfe0f_4163;
localparam int          NUM_PROGS   = 10;                  // legal random programs
localparam int          MAX_LEN     = 41;                  // 40 instr + ebreak
localparam int          FAB_CYCLES  = DMEM_DEPTH * 12 + MAX_LEN * 3 + 400;  // load, dump, poll
localparam longint      WATCHDOG_NS = longint'(NUM_PROGS + 4) * (MAX_LEN * 4 + FAB_CYCLES)
                                      * CLK_PERIOD * 2;

typedef enum int {K_ADDI, K_ADD, K_SUB, K_LUI, K_LW, K_SW} t_kind;

logic            Clock;
logic            rstN;
t_tile_id        localTileId;
logic            InFabricValidQ503H;
t_tile_trans     InFabricQ503H;
logic            mini_core_ready;
logic            OutFabricValidQ505H;
t_tile_trans     OutFabricQ505H;
t_fab_ready      fab_ready;

logic [XLEN-1:0] modelRegs [0:RF_NUM_MSB];                 // isa model state
logic [XLEN-1:0] modelMem  [0:DMEM_DEPTH-1];
bit              modelHalted;
bit              backPressure;                             // random RspReady when set

mini_core_top u_dut (
   .Clock               (Clock),
   .rstN                (rstN),
   .local_tile_id       (localTileId),
   .InFabricValidQ503H  (InFabricValidQ503H),
   .InFabricQ503H       (InFabricQ503H),
   .mini_core_ready     (mini_core_ready),
   .OutFabricValidQ505H (OutFabricValidQ505H),
   .OutFabricQ505H      (OutFabricQ505H),
   .fab_ready           (fab_ready)
);

initial begin
   Clock = 1'b0;
   forever #(CLK_PERIOD / 2) Clock = ~Clock;
end

initial begin
   #(WATCHDOG_NS);
   abortRun($sformatf("watchdog expired after %0d ns, the DUT stopped making progress",
                      WATCHDOG_NS));
end

//==========================================================================
//  checking
//==========================================================================
task automatic abortRun(input string msg);
   $display("%s", msg);
   $display("Test failed");
   $fatal(1, "simulation stopped on first error");
endtask

task automatic compareTrans(input t_tile_trans got, input t_tile_trans exp, input string what);
   if (got !== exp)
      abortRun($sformatf({"ERR %0t: %s got op=%0d addr=%h data=%h req=%h tgt=%h,",
                          " expected op=%0d addr=%h data=%h req=%h tgt=%h"},
                         $time, what, got.Opcode, got.Address, got.Data, got.Requestor,
                         got.Target, exp.Opcode, exp.Address, exp.Data, exp.Requestor,
                         exp.Target));
endtask

task automatic compareWord(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                           input string what);
   if (got !== exp)
      abortRun($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
endtask

//==========================================================================
//  fabric driver called on a falling edge
//==========================================================================
function automatic t_tile_id randTile();
   t_tile_id id;
   id.X = 4'($urandom_range(0, 15));
   id.Y = 4'($urandom_range(0, 15));
   return id;
endfunction

task automatic sendTrans(input t_tile_trans tr);
   InFabricValidQ503H = 1'b1;
   InFabricQ503H      = tr;
   while (!mini_core_ready) @(negedge Clock);              // ready only moves on rising edge
   @(negedge Clock);                                       // taken at the edge just passed
   InFabricValidQ503H = 1'b0;
   InFabricQ503H      = '0;
endtask

task automatic writeWord(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
   sendTrans('{Opcode: FAB_WR, Address: addr, Data: data, Requestor: randTile(),
               Target: localTileId});
endtask

task automatic readWord(input logic [XLEN-1:0] addr, output t_tile_trans rsp);
   t_tile_trans req;
   t_tile_trans exp;
   bit          seen;
   bit          taken;
   int          waits;
   seen  = 1'b0;
   taken = 1'b0;
   waits = 0;
   rsp   = '0;
   req   = '{Opcode: FAB_RD, Address: addr, Data: $urandom, Requestor: randTile(),
             Target: localTileId};
   sendTrans(req);
   while (!taken) begin
      fab_ready.RspReady = backPressure ? ($urandom_range(0, 2) == 0) : 1'b1;
      if (OutFabricValidQ505H) begin
         if (seen) compareTrans(OutFabricQ505H, rsp, "held response");  // must not move
         rsp   = OutFabricQ505H;
         seen  = 1'b1;
         taken = fab_ready.RspReady;                       // consumed at next rising edge
      end else if (seen) begin
         abortRun($sformatf("response to read of %h was dropped before it was taken", addr));
      end
      waits++;
      if (waits > 200) abortRun($sformatf("no response to fabric read of %h", addr));
      @(negedge Clock);
   end
   if (OutFabricValidQ505H)
      abortRun($sformatf("response to read of %h was sent twice", addr));
   exp = '{Opcode: FAB_RD_RSP, Address: addr, Data: rsp.Data, Requestor: req.Target,
           Target: req.Requestor};                         // ends swapped
   compareTrans(rsp, exp, "read response");
endtask

task automatic checkDmem();
   t_tile_trans rsp;
   for (int i = 0; i < DMEM_DEPTH; i++) begin
      readWord(DMEM_BASE + 32'(i) * 4, rsp);
      compareWord(rsp.Data, modelMem[i], $sformatf("dmem word %0d", i));
   end
endtask

task automatic pollHalted();
   t_tile_trans rsp;
   rsp = '0;
   while (!rsp.Data[1]) begin
      readWord(CTRL_ADDR, rsp);
      if (rsp.Data != 32'h1 && rsp.Data != 32'h2)        // running xor halted
         abortRun($sformatf("ERR %0t: control word %h is neither running nor halted",
                            $time, rsp.Data));
   end
endtask

//==========================================================================
//  programs and isa model
//==========================================================================
function automatic logic [31:0] encodeInstr(input t_kind kind, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [19:0] imm);
   case (kind)
      K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
      K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      K_LUI:   return {imm, rd, 7'b0110111};
      K_LW:    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
      default: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw
   endcase
endfunction

task automatic stepModel(input t_kind kind, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [19:0] imm);
   logic [XLEN-1:0] immI;
   logic [XLEN-1:0] addr;
   logic [XLEN-1:0] result;
   bit              bad;
   case (kind)                                             // only fields the instr uses
      K_LUI:        bad = rd > RF_NUM_MSB;
      K_SW:         bad = rs1 > RF_NUM_MSB || rs2 > RF_NUM_MSB;
      K_ADDI, K_LW: bad = rd > RF_NUM_MSB || rs1 > RF_NUM_MSB;
      default:      bad = rd > RF_NUM_MSB || rs1 > RF_NUM_MSB || rs2 > RF_NUM_MSB;
   endcase
   if (modelHalted || bad) begin
      modelHalted = 1'b1;                                  // nothing after this runs
      return;
   end
   immI = {{20{imm[11]}}, imm[11:0]};
   addr = modelRegs[rs1] + immI;
   case (kind)
      K_ADDI:  result = modelRegs[rs1] + immI;
      K_ADD:   result = modelRegs[rs1] + modelRegs[rs2];
      K_SUB:   result = modelRegs[rs1] - modelRegs[rs2];
      K_LUI:   result = {imm, 12'b0};
      K_LW:    result = modelMem[addr[DMEM_AW+1:2]];
      default: result = '0;
   endcase
   if (kind == K_SW) modelMem[addr[DMEM_AW+1:2]] = modelRegs[rs2];
   else if (rd != 5'd0) modelRegs[rd] = result;            // x0 stays zero
endtask

task automatic runProgram(input int len, input int badAt);
   logic [XLEN-1:0] prog [$];
   t_kind           kind;
   logic [4:0]      rd;
   logic [4:0]      rs1;
   logic [4:0]      rs2;
   logic [19:0]     imm;
   modelHalted = 1'b0;
   for (int i = 0; i < len; i++) begin
      kind = t_kind'($urandom_range(0, 5));
      rd   = 5'($urandom_range(0, RF_NUM_MSB));
      rs1  = 5'($urandom_range(0, RF_NUM_MSB));
      rs2  = 5'($urandom_range(0, RF_NUM_MSB));
      imm  = 20'($urandom);
      if (badAt >= 0 && i == badAt + 1) kind = K_SW;      // a store here shows a missed halt
      if (kind inside {K_LW, K_SW}) begin
         rs1 = 5'd0;                                       // base x0 keeps address in range
         imm = 20'($urandom_range(0, 63) * 4);             // small window for lots of reuse
      end
      if (i == badAt) begin
         kind = K_ADDI;
         rd   = 5'd20;                                     // beyond rv32e register count
      end
      prog.push_back(encodeInstr(kind, rd, rs1, rs2, imm));
      stepModel(kind, rd, rs1, rs2, imm);
   end
   prog.push_back(32'h0010_0073);                          // ebreak
   foreach (prog[i]) writeWord(IMEM_BASE + 32'(i) * 4, prog[i]);
   writeWord(CTRL_ADDR, 32'h1);                            // start
   pollHalted();
   checkDmem();
endtask

//==========================================================================
//  test sequence
//==========================================================================
initial begin
   t_tile_trans rsp;
   t_tile_trans tr;
   t_tile_id    otherTile;
   void'($urandom(SEED));
   rstN               = 1'b0;
   localTileId        = '{X: 4'd3, Y: 4'd6};
   InFabricValidQ503H = 1'b0;
   InFabricQ503H      = '0;
   fab_ready          = '{RspReady: 1'b1};
   backPressure       = 1'b0;
   modelHalted        = 1'b0;
   foreach (modelRegs[i]) modelRegs[i] = '0;               // rf clears on reset
   repeat (RST_CYCLES) @(posedge Clock);
   @(negedge Clock);
   rstN = 1'b1;
   @(negedge Clock);
   if (OutFabricValidQ505H || !mini_core_ready)
      abortRun("fabric port is not idle after reset");
   readWord(CTRL_ADDR, rsp);
   compareWord(rsp.Data, '0, "control word after reset");
   for (int i = 0; i < DMEM_DEPTH; i++) begin              // defined dmem for the programs
      modelMem[i] = $urandom;
      writeWord(DMEM_BASE + 32'(i) * 4, modelMem[i]);
   end
   checkDmem();
   backPressure = 1'b1;                                    // same data with a slow consumer
   checkDmem();
   repeat (NUM_PROGS) runProgram($urandom_range(20, 40), -1);
   runProgram(25, $urandom_range(5, 15));                  // halts on bad register
   otherTile   = localTileId;
   otherTile.X = localTileId.X + 4'd1;
   tr = '{Opcode: FAB_WR, Address: DMEM_BASE + 32'd20, Data: ~modelMem[5],
          Requestor: randTile(), Target: otherTile};
   sendTrans(tr);
   tr.Opcode = FAB_RD;
   sendTrans(tr);
   repeat (6) begin
      @(negedge Clock);
      if (OutFabricValidQ505H) abortRun("DUT answered a read addressed to another tile");
   end
   readWord(DMEM_BASE + 32'd20, rsp);
   compareWord(rsp.Data, modelMem[5], "dmem word 5 after write to another tile");
   $display("Test completed successfully");
   $finish;
end

endmodule

`default_nettype wire

// File: bench/mini_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mini_core_asserts
import common_pkg::*;
(
   input  logic            Clock,
   input  logic            rstN,
   input  logic            mini_core_ready,
   input  logic            OutFabricValidQ505H,
   input  var t_tile_trans OutFabricQ505H,
   input  var t_fab_ready  fab_ready,
   input  logic            fabAcc,
   input  var t_tile_trans InFabricQ503H,
   input  logic            fabImem,
   input  logic            fabWr,
   input  logic            runningQ
);

//==========================================================================
//  fabric response and imem protection
//==========================================================================
property rspHeld;                                          // stalled response frozen
   @(posedge Clock) disable iff (!rstN)
      OutFabricValidQ505H && !fab_ready.RspReady |=>
         OutFabricValidQ505H && $stable(OutFabricQ505H);
endproperty

property busyWhilePending;                                 // read blocks the port to q505
   @(posedge Clock) disable iff (!rstN)
      fabAcc && InFabricQ503H.Opcode == FAB_RD |=> !mini_core_ready ##1 !mini_core_ready;
endproperty

property busyWhileHeld;                                    // no new request meanwhile
   @(posedge Clock) disable iff (!rstN)
      OutFabricValidQ505H && !fab_ready.RspReady |=> !mini_core_ready;
endproperty

property noImemWriteWhileRunning;
   @(posedge Clock) disable iff (!rstN)
      fabImem && fabWr |-> !runningQ;
endproperty

assert property (rspHeld)
   else $error("fabric response changed or vanished while RspReady was low");
assert property (busyWhilePending)
   else $error("mini_core_ready high before an accepted read was answered");
assert property (busyWhileHeld)
   else $error("mini_core_ready high while a stalled response was held");
assert property (noImemWriteWhileRunning)
   else $error("fabric write to instruction memory while the core runs");

endmodule

bind mini_mem_wrap mini_core_asserts u_asserts (
   .Clock               (Clock),
   .rstN                (rstN),
   .mini_core_ready     (mini_core_ready),
   .OutFabricValidQ505H (OutFabricValidQ505H),
   .OutFabricQ505H      (OutFabricQ505H),
   .fab_ready           (fab_ready),
   .fabAcc              (fabAcc),
   .InFabricQ503H       (InFabricQ503H),
   .fabImem             (fabImem),
   .fabWr               (fabWr),
   .runningQ            (runningQ)
);

`default_nettype wire

// File: source/mini_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module mini_core_top
import common_pkg::*;
#(parameter int RF_NUM_MSB = common_pkg::RF_NUM_MSB)       // 15 keeps the rf rv32e sized
(
   input  logic            Clock,
   input  logic            rstN,
   input  t_tile_id        local_tile_id,
   //=======================================================================
   //  fabric side
   //=======================================================================
   input  logic            InFabricValidQ503H,
   input  var t_tile_trans InFabricQ503H,
   output logic            mini_core_ready,
   output logic            OutFabricValidQ505H,
   output var t_tile_trans OutFabricQ505H,
   input  var t_fab_ready  fab_ready
);

logic [XLEN-1:0] PcQ100H;                                  // to imem
t_instr          PreInstructionQ101H;                      // from imem
logic            ReadyQ101H;                               // fetch granted
logic            DMemReady;                                // dmem granted
t_core2mem_req   Core2DmemReqQ103H;                        // to dmem, kept packed
logic [XLEN-1:0] DMemRdRspQ104H;                           // from dmem
logic            RunQ100H;
logic            HaltQ102H;

mini_core #(.RF_NUM_MSB(RF_NUM_MSB)) mini_core (
   .Clock               (Clock),
   .rstN                (rstN),
   .RunQ100H            (RunQ100H),                        // from ctrl reg
   .HaltQ102H           (HaltQ102H),                       // ebreak / illegal
   .ReadyQ101H          (ReadyQ101H),
   .PcQ100H             (PcQ100H),
   .PreInstructionQ101H (PreInstructionQ101H),
   .DMemReady           (DMemReady),
   .Core2DmemReqQ103H   (Core2DmemReqQ103H),
   .DMemRdRspQ104H      (DMemRdRspQ104H)
);

mini_mem_wrap mini_mem_wrap (
   .Clock               (Clock),
   .rstN                (rstN),
   .local_tile_id       (local_tile_id),
   .PcQ100H             (PcQ100H),                         // core fetch port
   .ReadyQ101H          (ReadyQ101H),
   .PreInstructionQ101H (PreInstructionQ101H),
   .Core2DmemReqQ103H   (Core2DmemReqQ103H),               // core data port
   .DMemReady           (DMemReady),
   .DMemRdRspQ104H      (DMemRdRspQ104H),
   .RunQ100H            (RunQ100H),
   .HaltQ102H           (HaltQ102H),
   .InFabricValidQ503H  (InFabricValidQ503H),              // fabric port
   .InFabricQ503H       (InFabricQ503H),
   .mini_core_ready     (mini_core_ready),
   .OutFabricValidQ505H (OutFabricValidQ505H),
   .OutFabricQ505H      (OutFabricQ505H),
   .fab_ready           (fab_ready)
);

endmodule

`default_nettype wire

// File: source/mini_mem_wrap.sv
`timescale 1ns/1ps
`default_nettype none

module mini_mem_wrap
import common_pkg::*;
(
   input  logic              Clock,
   input  logic              rstN,
   input  t_tile_id          local_tile_id,
   // core fetch
   input  logic [XLEN-1:0]   PcQ100H,
   output logic              ReadyQ101H,
   output var t_instr        PreInstructionQ101H,
   // core data
   input  var t_core2mem_req Core2DmemReqQ103H,
   output logic              DMemReady,
   output logic [XLEN-1:0]   DMemRdRspQ104H,
   // run control
   output logic              RunQ100H,
   input  logic              HaltQ102H,
   // fabric
   input  logic              InFabricValidQ503H,
   input  var t_tile_trans   InFabricQ503H,
   output logic              mini_core_ready,
   output logic              OutFabricValidQ505H,
   output var t_tile_trans   OutFabricQ505H,
   input  var t_fab_ready    fab_ready
);

logic            fabAcc;
logic            fabWr;
logic            fabImem;
logic            fabDmem;
logic            fabCtrl;
logic            coreDmemReq;
logic            runningQ;
logic            haltedQ;
logic            rdValidQ504H;
t_tile_trans     rdTransQ504H;
logic            rdImemQ504H;
logic            rdDmemQ504H;
logic            rdCtrlQ504H;
logic [XLEN-1:0] ctrlSnapQ504H;
logic [XLEN-1:0] rspData;

//==========================================================================
//  fabric decode and port grant
//==========================================================================
// one request in flight; wrong target is swallowed
assign mini_core_ready = !rdValidQ504H && !OutFabricValidQ505H;
assign fabAcc  = InFabricValidQ503H && mini_core_ready && InFabricQ503H.Target == local_tile_id;
assign fabWr   = InFabricQ503H.Opcode == FAB_WR;
assign fabImem = fabAcc && InFabricQ503H.Address[31:16] == IMEM_BASE[31:16];
assign fabDmem = fabAcc && InFabricQ503H.Address[31:16] == DMEM_BASE[31:16];
assign fabCtrl = fabAcc && InFabricQ503H.Address == CTRL_ADDR;

assign ReadyQ101H  = !fabImem;                             // fabric wins
assign DMemReady   = !fabDmem;
assign coreDmemReq = Core2DmemReqQ103H.WrEn || Core2DmemReqQ103H.RdEn;

mini_mem #(.PayloadT(t_instr), .DEPTH(IMEM_DEPTH)) iMem (
   .Clock  (Clock),
   .En     (fabImem || RunQ100H),                          // fetch only while running
   .WrEn   (fabImem && fabWr),
   .Addr   (fabImem ? InFabricQ503H.Address[IMEM_AW+1:2] : PcQ100H[IMEM_AW+1:2]),
   .WrData (t_instr'(InFabricQ503H.Data)),
   .RdData (PreInstructionQ101H)
);

mini_mem #(.PayloadT(logic [XLEN-1:0]), .DEPTH(DMEM_DEPTH)) dMem (
   .Clock  (Clock),
   .En     (fabDmem || coreDmemReq),
   .WrEn   (fabDmem ? fabWr : Core2DmemReqQ103H.WrEn && &Core2DmemReqQ103H.ByteEn),
   .Addr   (fabDmem ? InFabricQ503H.Address[DMEM_AW+1:2]
                    : Core2DmemReqQ103H.Address[DMEM_AW+1:2]),
   .WrData (fabDmem ? InFabricQ503H.Data : Core2DmemReqQ103H.WrData),
   .RdData (DMemRdRspQ104H)
);

//==========================================================================
//  run / halt control register
//==========================================================================
assign RunQ100H = runningQ;

always_ff @(posedge Clock) begin
   if (!rstN) begin
      runningQ <= 1'b0;
      haltedQ  <= 1'b0;
   end else if (HaltQ102H) begin
      runningQ <= 1'b0;                                    // ebreak or illegal
      haltedQ  <= 1'b1;
   end else if (fabCtrl && fabWr && InFabricQ503H.Data[0]) begin
      runningQ <= 1'b1;
      haltedQ  <= 1'b0;
   end
end

//==========================================================================
//  read response, q504 then q505
//==========================================================================
assign rspData = rdImemQ504H ? XLEN'(PreInstructionQ101H) :
                 rdDmemQ504H ? DMemRdRspQ104H :
                 rdCtrlQ504H ? ctrlSnapQ504H : '0;         // unmapped reads 0

always_ff @(posedge Clock) begin
   if (!rstN) begin
      rdValidQ504H        <= 1'b0;
      OutFabricValidQ505H <= 1'b0;
   end else begin
      rdValidQ504H <= fabAcc && InFabricQ503H.Opcode == FAB_RD;
      if (rdValidQ504H) OutFabricValidQ505H <= 1'b1;
      else if (fab_ready.RspReady) OutFabricValidQ505H <= 1'b0;  // held until taken
   end
end

always_ff @(posedge Clock) begin
   if (fabAcc) begin
      rdTransQ504H  <= InFabricQ503H;
      rdImemQ504H   <= fabImem;
      rdDmemQ504H   <= fabDmem;
      rdCtrlQ504H   <= fabCtrl;
      ctrlSnapQ504H <= {30'b0, haltedQ, runningQ};
   end
   if (rdValidQ504H) begin
      OutFabricQ505H.Opcode    <= FAB_RD_RSP;
      OutFabricQ505H.Address   <= rdTransQ504H.Address;
      OutFabricQ505H.Data      <= rspData;
      OutFabricQ505H.Requestor <= rdTransQ504H.Target;     // swap ends
      OutFabricQ505H.Target    <= rdTransQ504H.Requestor;
   end
end

endmodule

`default_nettype wire

// File: source/mini_core.sv
`timescale 1ns/1ps
`default_nettype none

module mini_core
import common_pkg::*;
#(parameter int RF_NUM_MSB = common_pkg::RF_NUM_MSB)
(
   input  logic            Clock,
   input  logic            rstN,
   input  logic            RunQ100H,
   output logic            HaltQ102H,
   input  logic            ReadyQ101H,
   output logic [XLEN-1:0] PcQ100H,
   input  var t_instr      PreInstructionQ101H,
   input  logic            DMemReady,
   output var t_core2mem_req Core2DmemReqQ103H,
   input  logic [XLEN-1:0] DMemRdRspQ104H
);

typedef enum logic [2:0] {
   S_IDLE,
   S_FETCH,
   S_EXEC,
   S_MEM,
   S_WB
} t_state;

t_state          stateQ;
t_instr          irQ;                                      // latched at end of exec
t_instr          instrCur;
t_decoded        dec;
logic [XLEN-1:0] rs1Val;
logic [XLEN-1:0] rs2Val;
logic [XLEN-1:0] aluResult;
logic [XLEN-1:0] effAddr;
logic            isMemOp;
logic            rfWrEn;
logic [XLEN-1:0] rfWrData;

//==========================================================================
//  sequencer
//==========================================================================
// fresh word straight from imem in exec, ir afterwards
assign instrCur  = (stateQ == S_EXEC) ? PreInstructionQ101H : irQ;
assign isMemOp   = dec.Op inside {OP_LOAD, OP_STORE};
assign HaltQ102H = (stateQ == S_EXEC) && (dec.Op inside {OP_HALT, OP_ILLEGAL});

always_ff @(posedge Clock) begin
   if (!rstN) begin
      stateQ  <= S_IDLE;
      PcQ100H <= '0;
   end else begin
      case (stateQ)
         S_IDLE: begin
            PcQ100H <= '0;                                 // every run starts at 0
            if (RunQ100H) stateQ <= S_FETCH;
         end
         S_FETCH: if (ReadyQ101H) stateQ <= S_EXEC;        // wait out fabric on imem
         S_EXEC: begin
            if (HaltQ102H) begin
               stateQ <= S_IDLE;                           // pc stays on halting instr
            end else begin
               PcQ100H <= PcQ100H + 32'd4;
               stateQ  <= isMemOp ? S_MEM : S_WB;
            end
         end
         S_MEM:   if (DMemReady) stateQ <= S_WB;           // req held until granted
         S_WB:    stateQ <= S_FETCH;
         default: stateQ <= S_IDLE;
      endcase
   end
end

always_ff @(posedge Clock) begin
   if (stateQ == S_EXEC) irQ <= PreInstructionQ101H;
end

//==========================================================================
//  datapath
//==========================================================================
assign rfWrEn   = (stateQ == S_WB) && (dec.Op inside {OP_ADD, OP_SUB, OP_LUI, OP_LOAD});
assign rfWrData = (dec.Op == OP_LOAD) ? DMemRdRspQ104H : aluResult;

// dmem request, word accesses only
assign Core2DmemReqQ103H.WrData  = rs2Val;
assign Core2DmemReqQ103H.Address = effAddr;
assign Core2DmemReqQ103H.ByteEn  = 4'hF;
assign Core2DmemReqQ103H.WrEn    = (stateQ == S_MEM) && (dec.Op == OP_STORE);
assign Core2DmemReqQ103H.RdEn    = (stateQ == S_MEM) && (dec.Op == OP_LOAD);

mini_rf #(.RF_NUM_MSB(RF_NUM_MSB)) mini_rf (
   .Clock   (Clock),
   .rstN    (rstN),
   .RdAddr1 (dec.Rs1),
   .RdAddr2 (dec.Rs2),
   .RdData1 (rs1Val),
   .RdData2 (rs2Val),
   .WrEn    (rfWrEn),
   .WrAddr  (dec.Rd),
   .WrData  (rfWrData)
);

mini_alu #(.RF_NUM_MSB(RF_NUM_MSB)) mini_alu (
   .Instr   (instrCur),
   .Rs1Val  (rs1Val),
   .Rs2Val  (rs2Val),
   .Decoded (dec),
   .Result  (aluResult),
   .EffAddr (effAddr)
);

endmodule

`default_nettype wire

// File: source/mini_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mini_alu
import common_pkg::*;
#(parameter int RF_NUM_MSB = common_pkg::RF_NUM_MSB)
(
   input  var t_instr      Instr,
   input  logic [XLEN-1:0] Rs1Val,
   input  logic [XLEN-1:0] Rs2Val,
   output var t_decoded    Decoded,
   output logic [XLEN-1:0] Result,
   output logic [XLEN-1:0] EffAddr
);

logic [XLEN-1:0] immI;
logic [XLEN-1:0] immS;
logic [XLEN-1:0] immU;
logic            badRd;
logic            badRs1;
logic            badRs2;

assign immI   = {{20{Instr[31]}}, Instr[31:20]};
assign immS   = {{20{Instr[31]}}, Instr.Funct7, Instr.Rd};
assign immU   = {Instr[31:12], 12'b0};
assign badRd  = Instr.Rd  > RF_NUM_MSB;
assign badRs1 = Instr.Rs1 > RF_NUM_MSB;
assign badRs2 = Instr.Rs2 > RF_NUM_MSB;

//==========================================================================
//  decode
//==========================================================================
always_comb begin
   Decoded     = '{Op: OP_ILLEGAL, Rd: '0, Rs1: '0, Rs2: '0, Imm: '0};
   Decoded.Rd  = Instr.Rd;                                 // unused fields stay 0
   Decoded.Rs1 = Instr.Rs1;
   case (Instr.Opcode)
      OPC_OP_IMM: if (Instr.Funct3 == 3'b000 && !badRd && !badRs1) begin
         Decoded.Op  = OP_ADD;                             // addi, rs2 reads x0
         Decoded.Imm = immI;
      end
      OPC_OP: if (Instr.Funct3 == 3'b000 && !badRd && !badRs1 && !badRs2) begin
         Decoded.Rs2 = Instr.Rs2;
         if (Instr.Funct7 == 7'b0000000) Decoded.Op = OP_ADD;
         else if (Instr.Funct7 == 7'b0100000) Decoded.Op = OP_SUB;
      end
      OPC_LUI: if (!badRd) begin
         Decoded.Op  = OP_LUI;
         Decoded.Imm = immU;
      end
      OPC_LOAD: if (Instr.Funct3 == 3'b010 && !badRd && !badRs1) begin
         Decoded.Op  = OP_LOAD;                            // lw only
         Decoded.Imm = immI;
      end
      OPC_STORE: if (Instr.Funct3 == 3'b010 && !badRs1 && !badRs2) begin
         Decoded.Op  = OP_STORE;                           // sw only
         Decoded.Rd  = '0;
         Decoded.Rs2 = Instr.Rs2;
         Decoded.Imm = immS;
      end
      default: if (Instr == INSTR_EBREAK) Decoded.Op = OP_HALT;
   endcase
end

//==========================================================================
//  execute
//==========================================================================
assign EffAddr = Rs1Val + Decoded.Imm;

always_comb begin
   case (Decoded.Op)
      OP_ADD:  Result = Rs1Val + Rs2Val + Decoded.Imm;      // imm is 0 for add
      OP_SUB:  Result = Rs1Val - Rs2Val;
      OP_LUI:  Result = Decoded.Imm;
      default: Result = EffAddr;
   endcase
end

endmodule

`default_nettype wire

// File: source/mini_rf.sv
`timescale 1ns/1ps
`default_nettype none

module mini_rf
import common_pkg::*;
#(parameter int RF_NUM_MSB = common_pkg::RF_NUM_MSB)
(
   input  logic            Clock,
   input  logic            rstN,
   input  logic [4:0]      RdAddr1,
   input  logic [4:0]      RdAddr2,
   output logic [XLEN-1:0] RdData1,
   output logic [XLEN-1:0] RdData2,
   input  logic            WrEn,
   input  logic [4:0]      WrAddr,
   input  logic [XLEN-1:0] WrData
);

logic [XLEN-1:0] regsQ [1:RF_NUM_MSB];                     // x0 has no storage

// x0 and out-of-range indices read as zero
assign RdData1 = (RdAddr1 == '0 || RdAddr1 > RF_NUM_MSB) ? '0 : regsQ[RdAddr1];
assign RdData2 = (RdAddr2 == '0 || RdAddr2 > RF_NUM_MSB) ? '0 : regsQ[RdAddr2];

always_ff @(posedge Clock) begin
   if (!rstN) begin
      for (int i = 1; i <= RF_NUM_MSB; i++) regsQ[i] <= '0;
   end else if (WrEn && WrAddr != '0 && WrAddr <= RF_NUM_MSB) begin
      regsQ[WrAddr] <= WrData;                             // seen by reads next cycle
   end
end

endmodule

`default_nettype wire

// File: source/mini_mem.sv
`timescale 1ns/1ps
`default_nettype none

module mini_mem
#(
   parameter type PayloadT = logic [31:0],
   parameter int  DEPTH    = 256
)
(
   input  logic                     Clock,
   input  logic                     En,
   input  logic                     WrEn,
   input  logic [$clog2(DEPTH)-1:0] Addr,
   input  PayloadT                  WrData,
   output PayloadT                  RdData
);

PayloadT memQ [DEPTH];

always_ff @(posedge Clock) begin
   if (En) begin
      if (WrEn) memQ[Addr] <= WrData;
      RdData <= memQ[Addr];                                // old data on a write
   end
end

endmodule

`default_nettype wire

// File: source/common_pkg.sv
`default_nettype none

package common_pkg;

//==========================================================================
//  sizes and fabric memory map
//==========================================================================
localparam int XLEN       = 32;
localparam int IMEM_DEPTH = 256;                           // words
localparam int DMEM_DEPTH = 256;                           // words
localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
localparam int RF_NUM_MSB = 15;                            // rv32e default

localparam logic [XLEN-1:0] IMEM_BASE = 32'h0000_0000;
localparam logic [XLEN-1:0] DMEM_BASE = 32'h0001_0000;
localparam logic [XLEN-1:0] CTRL_ADDR = 32'h0002_0000;     // wr b0 start, rd {halted,running}

// rv32 major opcodes
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [XLEN-1:0] INSTR_EBREAK = 32'h0010_0073;

//==========================================================================
//  fabric types
//==========================================================================
typedef struct packed {
   logic [3:0] X;
   logic [3:0] Y;
} t_tile_id;

typedef enum logic [1:0] {
   FAB_WR,
   FAB_RD,
   FAB_RD_RSP
} t_fab_op;

typedef struct packed {
   t_fab_op         Opcode;
   logic [XLEN-1:0] Address;
   logic [XLEN-1:0] Data;
   t_tile_id        Requestor;                             // sender
   t_tile_id        Target;                                // receiver
} t_tile_trans;

typedef struct packed {
   logic RspReady;
} t_fab_ready;

//==========================================================================
//  core types
//==========================================================================
typedef struct packed {
   logic [XLEN-1:0] WrData;
   logic [XLEN-1:0] Address;                               // byte address in dmem
   logic [3:0]      ByteEn;
   logic            WrEn;
   logic            RdEn;
} t_core2mem_req;

typedef struct packed {
   logic [6:0] Funct7;
   logic [4:0] Rs2;
   logic [4:0] Rs1;
   logic [2:0] Funct3;
   logic [4:0] Rd;
   logic [6:0] Opcode;
} t_instr;

typedef enum logic [2:0] {
   OP_ADD,
   OP_SUB,
   OP_LUI,
   OP_LOAD,
   OP_STORE,
   OP_HALT,
   OP_ILLEGAL
} t_alu_op;

typedef struct packed {
   t_alu_op         Op;
   logic [4:0]      Rd;
   logic [4:0]      Rs1;
   logic [4:0]      Rs2;
   logic [XLEN-1:0] Imm;
} t_decoded;

endpackage

`default_nettype wire
